/* Makefile */
VERILATOR  ?= verilator
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
TOP        := proj_tb
FILELIST   := project.f
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then \
		echo "Simulation FAILED"; \
		exit 1; \
	fi
	@if ! grep -q "Testbench passed" $(LOG); then \
		echo "Simulation ended without a result"; \
		exit 1; \
	fi
	@echo "Simulation OK"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* project.f */
source/attn_pkg.sv
source/proj_ctrl.sv
source/operand_addr_gen.sv
source/mac_acc.sv
source/result_writer.sv
source/attn_proj_top.sv
sim/sram_model.sv
sim/proj_tb.sv

/* sim/proj_tb.sv */
// Projection stage testbench
`timescale 1ns/1ps

module proj_tb;

  localparam int NUM_JOBS = 24;
  localparam int MAX_DIM = 6;
  localparam int CLK_PERIOD = 10;
  localparam int SEED = 47;
  localparam int RESULT_FILL_WORDS = 256;

  logic            clk;
  logic            reset_n;
  logic            dut_valid;
  logic            dut_ready;
  attn_pkg::addr_t input_read_address;
  attn_pkg::data_t input_read_data;
  attn_pkg::addr_t weight_read_address;
  attn_pkg::data_t weight_read_data;
  logic            result_write_enable;
  attn_pkg::addr_t result_write_address;
  attn_pkg::data_t result_write_data;

  // Dimensions are drawn up front so the watchdog knows the budget
  int job_rows [NUM_JOBS];
  int job_inner [NUM_JOBS];
  int job_cols [NUM_JOBS];
  attn_pkg::data_t x_mat [MAX_DIM][MAX_DIM];
  attn_pkg::data_t w_mat [attn_pkg::NUM_PROJECTIONS][MAX_DIM][MAX_DIM];

  int   check_count;
  int   mismatch_count;
  int   other_error_count;
  int   write_count;
  logic job_active;
  logic budget_ready = 1'b0;
  int   budget_cycles;

  attn_proj_top i_attn_proj_top (
    .clk                  (clk),
    .reset_n              (reset_n),
    .dut_valid            (dut_valid),
    .dut_ready            (dut_ready),
    .input_read_address   (input_read_address),
    .input_read_data      (input_read_data),
    .weight_read_address  (weight_read_address),
    .weight_read_data     (weight_read_data),
    .result_write_enable  (result_write_enable),
    .result_write_address (result_write_address),
    .result_write_data    (result_write_data)
  );

  sram_model i_input_sram (
    .clk          (clk),
    .address      (input_read_address),
    .write_enable (1'b0),
    .write_data   ('0),
    .read_data    (input_read_data)
  );

  sram_model i_weight_sram (
    .clk          (clk),
    .address      (weight_read_address),
    .write_enable (1'b0),
    .write_data   ('0),
    .read_data    (weight_read_data)
  );

  sram_model i_result_sram (
    .clk          (clk),
    .address      (result_write_address),
    .write_enable (result_write_enable),
    .write_data   (result_write_data),
    .read_data    ()
  );

  initial begin
    clk = 1'b0;
  end

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic check_equal(input attn_pkg::data_t actual, input attn_pkg::data_t expected,
                             input string what);
    check_count++;
    if (actual !== expected) begin
      mismatch_count++;
      $display("mismatch at %0t: %s expected %h got %h", $time, what, expected, actual);
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic wait_for_ready();
    while (!dut_ready) begin
      @(posedge clk);
      #1;
    end
  endtask

  function automatic attn_pkg::data_t random_operand(input logic wide);
    if (wide) begin
      return $urandom;
    end
    return $urandom & 32'h0000_00ff;
  endfunction

  // Reference dot product wrapping at 32 bits
  function automatic attn_pkg::data_t expected_result(input int p, input int r, input int c,
                                                      input int k);
    attn_pkg::data_t acc;
    acc = '0;
    for (int i = 0; i < k; i++) begin
      acc = acc + x_mat[r][i] * w_mat[p][c][i];
    end
    return acc;
  endfunction

  task automatic plan_jobs();
    for (int j = 0; j < NUM_JOBS; j++) begin
      job_rows[j] = 1 + int'($urandom % MAX_DIM);
      job_inner[j] = 1 + int'($urandom % MAX_DIM);
      job_cols[j] = 1 + int'($urandom % MAX_DIM);
    end
    // Edge cases with unit dimensions
    job_rows[0] = 1;
    job_inner[1] = 1;
    job_cols[2] = 1;
    job_rows[3] = 1;
    job_inner[3] = 1;
    job_cols[3] = 1;
    budget_cycles = 100 + NUM_JOBS * 20;
    for (int j = 0; j < NUM_JOBS; j++) begin
      budget_cycles += 3 * job_rows[j] * job_cols[j] * (job_inner[j] + 2);
    end
  endtask

  task automatic load_operands(input int n, input int k, input int m, input logic wide);
    i_input_sram.write_word(attn_pkg::HEADER_ADDR, {attn_pkg::dim_t'(n), attn_pkg::dim_t'(k)});
    for (int r = 0; r < n; r++) begin
      for (int i = 0; i < k; i++) begin
        x_mat[r][i] = random_operand(wide);
        i_input_sram.write_word(attn_pkg::addr_t'(1 + r * k + i), x_mat[r][i]);
      end
    end
    i_weight_sram.write_word(attn_pkg::HEADER_ADDR, {attn_pkg::dim_t'(k), attn_pkg::dim_t'(m)});
    // Each projection is stored column by column
    for (int p = 0; p < attn_pkg::NUM_PROJECTIONS; p++) begin
      for (int c = 0; c < m; c++) begin
        for (int i = 0; i < k; i++) begin
          w_mat[p][c][i] = random_operand(wide);
          i_weight_sram.write_word(attn_pkg::addr_t'(1 + p * k * m + c * k + i), w_mat[p][c][i]);
        end
      end
    end
  endtask

  task automatic clear_results(input int salt);
    attn_pkg::addr_t addr;
    for (int a = 0; a < RESULT_FILL_WORDS; a++) begin
      addr = attn_pkg::addr_t'(a);
      i_result_sram.write_word(addr, {~addr, addr} ^ attn_pkg::data_t'(salt * 32'h0101_0101));
    end
  endtask

  task automatic check_results(input int n, input int k, input int m);
    attn_pkg::addr_t addr;
    for (int p = 0; p < attn_pkg::NUM_PROJECTIONS; p++) begin
      for (int r = 0; r < n; r++) begin
        for (int c = 0; c < m; c++) begin
          addr = attn_pkg::addr_t'(p * n * m + r * m + c);
          check_equal(i_result_sram.read_word(addr), expected_result(p, r, c, k),
                      $sformatf("result p%0d r%0d c%0d", p, r, c));
        end
      end
    end
  endtask

  task automatic run_job(input int idx);
    int   n;
    int   k;
    int   m;
    logic wide;
    n = job_rows[idx];
    k = job_inner[idx];
    m = job_cols[idx];
    wide = (idx % 2 == 1);
    load_operands(n, k, m, wide);
    clear_results(idx);
    write_count = 0;
    job_active = 1'b1;
    dut_valid = 1'b1;
    @(posedge clk);
    #1;
    dut_valid = 1'b0;
    check_equal(32'(dut_ready), 32'(0), "dut_ready after accepted request");
    // Stray request while busy must be ignored
    if (idx % 3 == 1) begin
      @(posedge clk);
      #1;
      if (!dut_ready) begin
        dut_valid = 1'b1;
        @(posedge clk);
        #1;
        dut_valid = 1'b0;
      end
    end
    wait_for_ready();
    check_equal(32'(write_count), 32'(3 * n * m), "result write count");
    check_results(n, k, m);
    job_active = 1'b0;
  endtask

  // Write monitor sampled mid-cycle
  always @(negedge clk) begin
    if (reset_n && result_write_enable) begin
      if (!job_active) begin
        other_error_count++;
        $display("Result write at %0t while no job was running", $time);
      end else begin
        check_equal(32'(result_write_address), 32'(write_count), "result write address");
        write_count++;
      end
    end
  end

  initial begin : watchdog
    wait (budget_ready);
    repeat (budget_cycles) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles", budget_cycles);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    int gap;
    void'($urandom(SEED));
    reset_n = 1'b0;
    dut_valid = 1'b0;
    check_count = 0;
    mismatch_count = 0;
    other_error_count = 0;
    write_count = 0;
    job_active = 1'b0;
    plan_jobs();
    budget_ready = 1'b1;

    repeat (2) @(posedge clk);
    #1;
    check_equal(32'(dut_ready), 32'(0), "dut_ready in reset");
    check_equal(32'(result_write_enable), 32'(0), "result_write_enable in reset");
    reset_n = 1'b1;
    @(posedge clk);
    #1;
    check_equal(32'(dut_ready), 32'(1), "dut_ready after reset");
    check_equal(32'(input_read_address), 32'(attn_pkg::HEADER_ADDR), "idle input address");
    check_equal(32'(weight_read_address), 32'(attn_pkg::HEADER_ADDR), "idle weight address");
    wait_cycles(3);

    for (int j = 0; j < NUM_JOBS; j++) begin
      run_job(j);
      gap = int'($urandom % 4);
      wait_cycles(gap);
    end
    wait_cycles(5);

    $display("Summary: %0d checks, %0d mismatches, %0d other errors",
             check_count, mismatch_count, other_error_count);
    if (mismatch_count == 0 && other_error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* sim/sram_model.sv */
// Behavioral single-port SRAM
`timescale 1ns/1ps

module sram_model #(
  parameter int DEPTH = 1 << attn_pkg::ADDR_WIDTH
) (
  input  logic            clk,
  input  attn_pkg::addr_t address,
  input  logic            write_enable,
  input  attn_pkg::data_t write_data,
  output attn_pkg::data_t read_data
);

  attn_pkg::data_t mem [DEPTH];

  // Power-up contents tell every word apart
  initial begin
    for (int a = 0; a < DEPTH; a++) begin
      mem[a] = {~attn_pkg::addr_t'(a), attn_pkg::addr_t'(a)};
    end
  end

  // Read returns the old word when a write hits the same address
  always @(posedge clk) begin
    read_data <= mem[address];
    if (write_enable) begin
      mem[address] = write_data;
    end
  end

  // Backdoor access for the testbench
  task automatic write_word(input attn_pkg::addr_t a, input attn_pkg::data_t d);
    mem[a] = d;
  endtask

  function automatic attn_pkg::data_t read_word(input attn_pkg::addr_t a);
    return mem[a];
  endfunction

endmodule

/* source/attn_pkg.sv */
// Attention projection definitions
package attn_pkg;

  localparam int DATA_WIDTH = 32;
  localparam int ADDR_WIDTH = 16;
  // Two dimensions share one header word
  localparam int DIM_WIDTH = DATA_WIDTH / 2;

  localparam int NUM_PROJECTIONS = 3;
  localparam int PROJ_WIDTH = $clog2(NUM_PROJECTIONS);
  localparam logic [PROJ_WIDTH-1:0] LAST_PROJECTION = PROJ_WIDTH'(NUM_PROJECTIONS - 1);

  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DIM_WIDTH-1:0] dim_t;

  // Memory layout
  localparam addr_t HEADER_ADDR = addr_t'(0);
  localparam addr_t FIRST_ELEMENT_ADDR = addr_t'(1);

  // Job FSM encoding
  localparam int STATE_WIDTH = 2;
  localparam logic [STATE_WIDTH-1:0] ST_IDLE = 2'd0;
  localparam logic [STATE_WIDTH-1:0] ST_LOAD_DIMS = 2'd1;
  localparam logic [STATE_WIDTH-1:0] ST_STREAMING = 2'd2;
  localparam logic [STATE_WIDTH-1:0] ST_DONE = 2'd3;

  // Header holds rows in the upper half, cols in the lower
  typedef union packed {
    data_t raw;
    struct packed {
      dim_t rows;
      dim_t cols;
    } header;
  } sram_word_t;

endpackage

/* source/attn_proj_top.sv */
// Attention projection top level
`timescale 1ns/1ps

module attn_proj_top (
  input  logic            clk,
  input  logic            reset_n,
  input  logic            dut_valid,
  output logic            dut_ready,
  output attn_pkg::addr_t input_read_address,
  input  attn_pkg::data_t input_read_data,
  output attn_pkg::addr_t weight_read_address,
  input  attn_pkg::data_t weight_read_data,
  output logic            result_write_enable,
  output attn_pkg::addr_t result_write_address,
  output attn_pkg::data_t result_write_data
);

  logic           stream_start;
  logic           write_done;
  attn_pkg::dim_t in_rows;
  attn_pkg::dim_t in_cols;
  attn_pkg::dim_t wt_cols;
  logic           operand_valid;
  logic           operand_last;
  logic           result_valid;
  attn_pkg::data_t result_data;

  proj_ctrl i_proj_ctrl (
    .clk              (clk),
    .reset_n          (reset_n),
    .dut_valid        (dut_valid),
    .dut_ready        (dut_ready),
    .input_read_data  (input_read_data),
    .weight_read_data (weight_read_data),
    .write_done       (write_done),
    .stream_start     (stream_start),
    .in_rows          (in_rows),
    .in_cols          (in_cols),
    .wt_cols          (wt_cols)
  );

  operand_addr_gen i_operand_addr_gen (
    .clk                 (clk),
    .reset_n             (reset_n),
    .stream_start        (stream_start),
    .in_rows             (in_rows),
    .in_cols             (in_cols),
    .wt_cols             (wt_cols),
    .input_read_address  (input_read_address),
    .weight_read_address (weight_read_address),
    .operand_valid       (operand_valid),
    .operand_last        (operand_last)
  );

  // Read data meets its tags one cycle after issue
  mac_acc i_mac_acc (
    .clk              (clk),
    .reset_n          (reset_n),
    .operand_valid    (operand_valid),
    .operand_last     (operand_last),
    .input_read_data  (input_read_data),
    .weight_read_data (weight_read_data),
    .result_valid     (result_valid),
    .result_data      (result_data)
  );

  result_writer i_result_writer (
    .clk                  (clk),
    .reset_n              (reset_n),
    .result_valid         (result_valid),
    .result_data          (result_data),
    .in_rows              (in_rows),
    .wt_cols              (wt_cols),
    .result_write_enable  (result_write_enable),
    .result_write_address (result_write_address),
    .result_write_data    (result_write_data),
    .write_done           (write_done)
  );

endmodule

/* source/mac_acc.sv */
// Dot product accumulator
`timescale 1ns/1ps

module mac_acc (
  input  logic            clk,
  input  logic            reset_n,
  input  logic            operand_valid,
  input  logic            operand_last,
  input  attn_pkg::data_t input_read_data,
  input  attn_pkg::data_t weight_read_data,
  output logic            result_valid,
  output attn_pkg::data_t result_data
);

  logic            tag_valid;
  logic            tag_last;
  logic            fresh;
  attn_pkg::data_t acc;
  attn_pkg::data_t product;
  attn_pkg::data_t sum;

  // Tags follow the addresses, data arrives one cycle later
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      tag_valid <= 1'b0;
      tag_last  <= 1'b0;
    end else begin
      tag_valid <= operand_valid;
      tag_last  <= operand_last;
    end
  end

  // Low 32 bits only
  assign product = input_read_data * weight_read_data;
  assign sum = (fresh ? attn_pkg::data_t'(0) : acc) + product;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      fresh <= 1'b1;
    end else if (tag_valid) begin
      fresh <= tag_last;
    end
  end

  always_ff @(posedge clk) begin
    if (tag_valid) begin
      acc <= sum;
    end
  end

  assign result_valid = tag_valid && tag_last;
  assign result_data = sum;

endmodule

/* source/operand_addr_gen.sv */
// Operand read address generator
`timescale 1ns/1ps

module operand_addr_gen (
  input  logic            clk,
  input  logic            reset_n,
  input  logic            stream_start,
  input  attn_pkg::dim_t  in_rows,
  input  attn_pkg::dim_t  in_cols,
  input  attn_pkg::dim_t  wt_cols,
  output attn_pkg::addr_t input_read_address,
  output attn_pkg::addr_t weight_read_address,
  output logic            operand_valid,
  output logic            operand_last
);

  attn_pkg::dim_t                  k_cnt;
  attn_pkg::dim_t                  c_cnt;
  attn_pkg::dim_t                  r_cnt;
  logic [attn_pkg::PROJ_WIDTH-1:0] p_cnt;
  attn_pkg::addr_t                 row_base;
  attn_pkg::addr_t                 proj_base;
  logic                            k_end;
  logic                            c_end;
  logic                            r_end;
  logic                            p_end;

  assign k_end = (k_cnt == in_cols - 1'b1);
  assign c_end = (c_cnt == wt_cols - 1'b1);
  assign r_end = (r_cnt == in_rows - 1'b1);
  assign p_end = (p_cnt == attn_pkg::LAST_PROJECTION);

  // Last pair of each dot product
  assign operand_last = operand_valid && k_end;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      operand_valid       <= 1'b0;
      k_cnt               <= '0;
      c_cnt               <= '0;
      r_cnt               <= '0;
      p_cnt               <= '0;
      row_base            <= attn_pkg::FIRST_ELEMENT_ADDR;
      proj_base           <= attn_pkg::FIRST_ELEMENT_ADDR;
      input_read_address  <= attn_pkg::HEADER_ADDR;
      weight_read_address <= attn_pkg::HEADER_ADDR;
    end else if (stream_start) begin
      operand_valid       <= 1'b1;
      k_cnt               <= '0;
      c_cnt               <= '0;
      r_cnt               <= '0;
      p_cnt               <= '0;
      row_base            <= attn_pkg::FIRST_ELEMENT_ADDR;
      proj_base           <= attn_pkg::FIRST_ELEMENT_ADDR;
      input_read_address  <= attn_pkg::FIRST_ELEMENT_ADDR;
      weight_read_address <= attn_pkg::FIRST_ELEMENT_ADDR;
    end else if (operand_valid) begin
      if (!k_end) begin
        k_cnt               <= k_cnt + 1'b1;
        input_read_address  <= input_read_address + 1'b1;
        weight_read_address <= weight_read_address + 1'b1;
      end else begin
        k_cnt <= '0;
        if (!c_end) begin
          // Same input row against the next weight column
          c_cnt               <= c_cnt + 1'b1;
          input_read_address  <= row_base;
          weight_read_address <= weight_read_address + 1'b1;
        end else begin
          c_cnt <= '0;
          if (!r_end) begin
            // Next row, weights rewind to the projection start
            r_cnt               <= r_cnt + 1'b1;
            row_base            <= row_base + in_cols;
            input_read_address  <= row_base + in_cols;
            weight_read_address <= proj_base;
          end else begin
            r_cnt    <= '0;
            row_base <= attn_pkg::FIRST_ELEMENT_ADDR;
            if (!p_end) begin
              // Next projection follows directly in weight memory
              p_cnt               <= p_cnt + 1'b1;
              proj_base           <= weight_read_address + 1'b1;
              input_read_address  <= attn_pkg::FIRST_ELEMENT_ADDR;
              weight_read_address <= weight_read_address + 1'b1;
            end else begin
              p_cnt               <= '0;
              operand_valid       <= 1'b0;
              input_read_address  <= attn_pkg::HEADER_ADDR;
              weight_read_address <= attn_pkg::HEADER_ADDR;
            end
          end
        end
      end
    end
  end

  // Reads stay inside the matrices the headers describe
  a_addr_in_range: assert property (
    @(posedge clk) disable iff (!reset_n)
    operand_valid |->
      (32'(input_read_address) <= 32'(in_rows) * 32'(in_cols)) &&
      (32'(weight_read_address) <=
        32'(attn_pkg::NUM_PROJECTIONS) * 32'(in_cols) * 32'(wt_cols))
  ) else $error("operand address beyond header size");

endmodule

/* source/proj_ctrl.sv */
// Projection job controller
`timescale 1ns/1ps

module proj_ctrl (
  input  logic            clk,
  input  logic            reset_n,
  input  logic            dut_valid,
  output logic            dut_ready,
  input  attn_pkg::data_t input_read_data,
  input  attn_pkg::data_t weight_read_data,
  input  logic            write_done,
  output logic            stream_start,
  output attn_pkg::dim_t  in_rows,
  output attn_pkg::dim_t  in_cols,
  output attn_pkg::dim_t  wt_cols
);

  logic [attn_pkg::STATE_WIDTH-1:0] state;
  logic [attn_pkg::STATE_WIDTH-1:0] next_state;
  attn_pkg::sram_word_t             in_header;
  attn_pkg::sram_word_t             wt_header;

  // Both read ports sit on the header address while idle
  assign in_header.raw = input_read_data;
  assign wt_header.raw = weight_read_data;

  always_comb begin
    next_state = state;
    case (state)
      attn_pkg::ST_IDLE: begin
        // Requests are taken only while ready is shown
        if (dut_valid && dut_ready) begin
          next_state = attn_pkg::ST_LOAD_DIMS;
        end
      end
      attn_pkg::ST_LOAD_DIMS: begin
        next_state = attn_pkg::ST_STREAMING;
      end
      attn_pkg::ST_STREAMING: begin
        if (write_done) begin
          next_state = attn_pkg::ST_DONE;
        end
      end
      attn_pkg::ST_DONE: begin
        next_state = attn_pkg::ST_IDLE;
      end
      default: begin
        next_state = attn_pkg::ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state        <= attn_pkg::ST_IDLE;
      dut_ready    <= 1'b0;
      stream_start <= 1'b0;
      in_rows      <= '0;
      in_cols      <= '0;
      wt_cols      <= '0;
    end else begin
      state        <= next_state;
      dut_ready    <= (next_state == attn_pkg::ST_IDLE);
      // One strobe, a cycle after the dimensions are held
      stream_start <= (state == attn_pkg::ST_LOAD_DIMS);
      if (state == attn_pkg::ST_LOAD_DIMS) begin
        in_rows <= in_header.header.rows;
        in_cols <= in_header.header.cols;
        wt_cols <= wt_header.header.cols;
      end
    end
  end

  // Inner dimensions of X and W must agree
  a_header_match: assert property (
    @(posedge clk) disable iff (!reset_n)
    (state == attn_pkg::ST_LOAD_DIMS) |-> (wt_header.header.rows == in_header.header.cols)
  ) else $error("weight header rows differ from input header cols");

  // No second stream until the job has written its last result
  a_single_start: assert property (
    @(posedge clk) disable iff (!reset_n)
    stream_start |=> (!stream_start throughout write_done [->1])
  ) else $error("stream_start repeated within one job");

endmodule

/* source/result_writer.sv */
// Result SRAM writer
`timescale 1ns/1ps

module result_writer (
  input  logic            clk,
  input  logic            reset_n,
  input  logic            result_valid,
  input  attn_pkg::data_t result_data,
  input  attn_pkg::dim_t  in_rows,
  input  attn_pkg::dim_t  wt_cols,
  output logic            result_write_enable,
  output attn_pkg::addr_t result_write_address,
  output attn_pkg::data_t result_write_data,
  output logic            write_done
);

  attn_pkg::addr_t total_writes;
  logic            last_write;

  // Three N by M products per job
  assign total_writes = attn_pkg::addr_t'(attn_pkg::NUM_PROJECTIONS) * in_rows * wt_cols;
  assign last_write = (result_write_address == total_writes - 1'b1);
  assign write_done = result_write_enable && last_write;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      result_write_enable  <= 1'b0;
      result_write_address <= '0;
    end else begin
      result_write_enable <= result_valid;
      // Address doubles as the write count, cleared for the next job
      if (write_done) begin
        result_write_address <= '0;
      end else if (result_write_enable) begin
        result_write_address <= result_write_address + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (result_valid) begin
      result_write_data <= result_data;
    end
  end

  // Upstream must not produce more sums than the job holds
  a_no_extra_write: assert property (
    @(posedge clk) disable iff (!reset_n)
    result_write_enable |-> (result_write_address < total_writes)
  ) else $error("result write after job count complete");

endmodule
